//--- files.f
rtl/dcache_pkg.sv
rtl/dcache_way.sv
rtl/dcache_way_merge.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
tests/mem_model.sv
tests/tb_dcache.sv

//--- rtl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_valid_i,
    input  dcache_pkg::cpu_req_t            req_i,
    output logic                            req_ready_o,
    output logic                            resp_valid_o,
    output logic [dcache_pkg::DATA_W-1:0]   resp_data_o,
    output logic                            mem_rd_req_o,
    output logic [dcache_pkg::ADDR_W-1:0]   mem_rd_addr_o,
    input  logic                            mem_rd_ready_i,
    input  logic [dcache_pkg::DATA_W-1:0]   mem_rdata_i,
    input  logic                            mem_rvalid_i,
    input  logic                            mem_rlast_i,
    output logic                            mem_wr_req_o,
    output dcache_pkg::mem_wr_t             mem_wr_o,
    input  logic                            mem_wr_ready_i,
    output dcache_pkg::way_wr_t             way_wr_o,
    output logic [dcache_pkg::NUM_WAYS-1:0] way_sel_o,
    output logic [dcache_pkg::INDEX_W-1:0]  lookup_index_o,
    output logic [dcache_pkg::INDEX_W-1:0]  read_index_o,
    output logic [dcache_pkg::TAG_W-1:0]    lookup_tag_o,
    input  logic                            hit_i,
    input  logic                            hit_way_i,
    input  logic [dcache_pkg::LINE_W-1:0]   hit_line_i,
    input  logic                            victim_way_i,
    input  dcache_pkg::tag_entry_t          victim_entry_i,
    input  logic [dcache_pkg::LINE_W-1:0]   victim_line_i,
    output logic                            touch_o,
    output logic                            touch_way_o
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_LOOKUP, S_WB, S_RDREQ, S_RDATA, S_REFILL} state_t;

    state_t                   state_q;
    state_t                   state_d;
    cpu_req_t                 req_q;
    logic                     hit_q;
    logic                     hit_way_q;
    logic                     victim_way_q;
    logic                     victim_dirty_q;
    logic [TAG_W-1:0]         victim_tag_q;
    logic [LINE_W-1:0]        refill_q;
    logic [$clog2(BEATS)-1:0] beat_q;
    logic [LINE_W-1:0]        wline;
    logic [LINE_W/8-1:0]      wmask;
    logic [LINE_W-1:0]        merged_line;
    logic [LINE_W-1:0]        resp_line;
    logic [INDEX_W-1:0]       index_q;
    logic [TAG_W-1:0]         tag_q;
    logic                     upper_half;
    logic                     accept;
    logic                     victim_dirty;

    assign index_q    = req_q.addr[OFFSET_W +: INDEX_W];
    assign tag_q      = req_q.addr[ADDR_W-1 -: TAG_W];
    assign upper_half = req_q.addr[OFFSET_W-1];

    // one-cycle stall after any buffered write
    assign req_ready_o  = (state_q == S_IDLE) || (state_q == S_LOOKUP && !req_q.op);
    assign accept       = req_valid_i && req_ready_o;
    assign victim_dirty = victim_entry_i.valid && victim_entry_i.dirty;

    assign lookup_index_o = req_ready_o ? req_i.addr[OFFSET_W +: INDEX_W] : index_q;
    assign read_index_o   = lookup_index_o;   // keeps the buffered set's line while busy
    assign lookup_tag_o   = req_i.addr[ADDR_W-1 -: TAG_W];
    assign touch_o        = accept;
    assign touch_way_o    = hit_i ? hit_way_i : victim_way_i;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q          <= req_i;
            hit_q          <= hit_i;
            hit_way_q      <= hit_way_i;
            victim_way_q   <= victim_way_i;
            victim_dirty_q <= victim_dirty;
            victim_tag_q   <= victim_entry_i.tag;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE, S_LOOKUP: begin
                if (!accept) begin
                    state_d = S_IDLE;
                end else if (hit_i) begin
                    state_d = S_LOOKUP;
                end else begin
                    state_d = victim_dirty ? S_WB : S_RDREQ;
                end
            end
            S_WB:     if (mem_wr_ready_i) state_d = S_RDREQ;
            S_RDREQ:  if (mem_rd_ready_i) state_d = S_RDATA;
            S_RDATA:  if (mem_rvalid_i && mem_rlast_i) state_d = S_REFILL;
            default:  state_d = S_IDLE;     // refill lasts one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // beat assembly, lower half first
    always_ff @(posedge clk) begin
        if (rst || state_q == S_RDREQ) begin
            beat_q <= '0;
        end else if (state_q == S_RDATA && mem_rvalid_i) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_RDATA && mem_rvalid_i) begin
            refill_q[beat_q*DATA_W +: DATA_W] <= mem_rdata_i;
        end
    end

    assign mem_rd_req_o  = (state_q == S_RDREQ);
    assign mem_rd_addr_o = {req_q.addr[ADDR_W-1:OFFSET_W], OFFSET_W'(0)};
    assign mem_wr_req_o  = (state_q == S_WB) && victim_dirty_q;
    assign mem_wr_o      = '{addr: {victim_tag_q, index_q, OFFSET_W'(0)}, line: victim_line_i};

    // write data placed on both halves, mask picks the one addressed
    assign wline = {BEATS{req_q.wdata}};
    assign wmask = upper_half ? {req_q.wstrb, STRB_W'(0)} : {STRB_W'(0), req_q.wstrb};

    always_comb begin
        for (int b = 0; b < LINE_W / 8; b++) begin
            merged_line[b*8 +: 8] = wmask[b] ? wline[b*8 +: 8] : refill_q[b*8 +: 8];
        end
    end

    always_comb begin
        way_wr_o             = '0;
        way_sel_o            = '0;
        way_wr_o.index       = index_q;
        way_wr_o.entry.tag   = tag_q;
        way_wr_o.entry.valid = 1'b1;
        if (state_q == S_LOOKUP && req_q.op) begin  // write hit
            way_wr_o.wen         = 1'b1;
            way_wr_o.entry.dirty = 1'b1;
            way_wr_o.line        = wline;
            way_wr_o.mask        = wmask;
            way_sel_o[hit_way_q] = 1'b1;
        end else if (state_q == S_REFILL) begin
            way_wr_o.wen            = 1'b1;
            way_wr_o.entry.dirty    = req_q.op;  // clean after a read refill
            way_wr_o.line           = req_q.op ? merged_line : refill_q;
            way_wr_o.mask           = '1;
            way_sel_o[victim_way_q] = 1'b1;
        end
    end

    assign resp_valid_o = (state_q == S_LOOKUP) || (state_q == S_REFILL);
    assign resp_line    = hit_q ? hit_line_i : refill_q;
    assign resp_data_o  = upper_half ? resp_line[LINE_W-1 -: DATA_W] : resp_line[DATA_W-1:0];

    assert property (@(posedge clk) disable iff (rst) !(mem_rd_req_o && mem_wr_req_o));
    assert property (@(posedge clk) disable iff (rst) resp_valid_o |-> state_q != S_IDLE);

endmodule

//--- rtl/dcache_pkg.sv
package dcache_pkg;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 64;
    localparam int LINE_W   = 128;
    localparam int NUM_WAYS = 2;
    localparam int OFFSET_W = 4;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int STRB_W   = DATA_W / 8;
    localparam int BEATS    = LINE_W / DATA_W;
    localparam int NUM_SETS = 1 << INDEX_W;

    typedef struct packed {
        logic              op;      // 1 = write
        logic [ADDR_W-1:0] addr;
        logic [STRB_W-1:0] wstrb;
        logic [DATA_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
        logic             dirty;
    } tag_entry_t;

    // one write into a way, tag entry and masked line together
    typedef struct packed {
        logic                wen;
        logic [INDEX_W-1:0]  index;
        tag_entry_t          entry;
        logic [LINE_W-1:0]   line;
        logic [LINE_W/8-1:0] mask;  // byte enables over the line
    } way_wr_t;

    typedef struct packed {
        tag_entry_t        entry;   // at lookup index, same cycle
        logic [LINE_W-1:0] line;    // at read index, one cycle later
    } way_rd_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] line;
    } mem_wr_t;

endpackage

//--- rtl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid_i,
    input  dcache_pkg::cpu_req_t          req_i,
    output logic                          req_ready_o,
    output logic                          resp_valid_o,
    output logic [dcache_pkg::DATA_W-1:0] resp_data_o,
    output logic                          mem_rd_req_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_rd_addr_o,
    input  logic                          mem_rd_ready_i,
    input  logic [dcache_pkg::DATA_W-1:0] mem_rdata_i,
    input  logic                          mem_rvalid_i,
    input  logic                          mem_rlast_i,
    output logic                          mem_wr_req_o,
    output dcache_pkg::mem_wr_t           mem_wr_o,
    input  logic                          mem_wr_ready_i
);
    import dcache_pkg::*;

    way_wr_t                  way_wr;
    logic [NUM_WAYS-1:0]      way_sel;
    logic [INDEX_W-1:0]       lookup_index;
    logic [INDEX_W-1:0]       read_index;
    logic [TAG_W-1:0]         lookup_tag;
    way_rd_t [NUM_WAYS-1:0]   ways_rd;
    logic                     hit;
    logic                     hit_way;
    logic [LINE_W-1:0]        hit_line;
    logic                     victim_way;
    tag_entry_t               victim_entry;
    logic [LINE_W-1:0]        victim_line;
    logic                     touch;
    logic                     touch_way;

    dcache_ctrl u_ctrl (
        .clk, .rst, .req_valid_i, .req_i, .req_ready_o, .resp_valid_o, .resp_data_o,
        .mem_rd_req_o, .mem_rd_addr_o, .mem_rd_ready_i, .mem_rdata_i, .mem_rvalid_i,
        .mem_rlast_i, .mem_wr_req_o, .mem_wr_o, .mem_wr_ready_i,
        .way_wr_o(way_wr), .way_sel_o(way_sel), .lookup_index_o(lookup_index),
        .read_index_o(read_index), .lookup_tag_o(lookup_tag), .hit_i(hit),
        .hit_way_i(hit_way), .hit_line_i(hit_line), .victim_way_i(victim_way),
        .victim_entry_i(victim_entry), .victim_line_i(victim_line),
        .touch_o(touch), .touch_way_o(touch_way)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        dcache_way u_way (
            .clk, .rst, .wr_i(way_wr), .sel_i(way_sel[w]), .lookup_index_i(lookup_index),
            .read_index_i(read_index), .rd_o(ways_rd[w])
        );
    end

    dcache_way_merge u_merge (
        .clk, .rst, .ways_i(ways_rd), .lookup_tag_i(lookup_tag), .touch_i(touch),
        .touch_way_i(touch_way), .touch_index_i(lookup_index), .hit_o(hit),
        .hit_way_o(hit_way), .hit_line_o(hit_line), .victim_way_o(victim_way),
        .victim_entry_o(victim_entry), .victim_line_o(victim_line)
    );

endmodule

//--- rtl/dcache_way.sv
`timescale 1ns/1ps

module dcache_way (
    input  logic                           clk,
    input  logic                           rst,
    input  dcache_pkg::way_wr_t            wr_i,
    input  logic                           sel_i,
    input  logic [dcache_pkg::INDEX_W-1:0] lookup_index_i,
    input  logic [dcache_pkg::INDEX_W-1:0] read_index_i,
    output dcache_pkg::way_rd_t            rd_o
);
    import dcache_pkg::*;

    logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
    logic [LINE_W-1:0]   data_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    logic [LINE_W-1:0]   line_q;
    logic                wr_en;

    assign wr_en = wr_i.wen && sel_i;

    // line state, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_i.index] <= wr_i.entry.valid;
            dirty_q[wr_i.index] <= wr_i.entry.dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_i.index] <= wr_i.entry.tag;
        end
    end

    // per-byte merge into the stored line
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < LINE_W / 8; b++) begin
                if (wr_i.mask[b]) begin
                    data_mem[wr_i.index][b*8 +: 8] <= wr_i.line[b*8 +: 8];
                end
            end
        end
    end

    // synchronous line read
    always_ff @(posedge clk) begin
        line_q <= data_mem[read_index_i];
    end

    always_comb begin
        rd_o.entry.tag   = tag_mem[lookup_index_i];   // tag read is combinational
        rd_o.entry.valid = valid_q[lookup_index_i];
        rd_o.entry.dirty = dirty_q[lookup_index_i];
        rd_o.line        = line_q;
    end

    // controller never marks an invalid line dirty
    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> (wr_i.entry.valid || !wr_i.entry.dirty));

endmodule

//--- rtl/dcache_way_merge.sv
`timescale 1ns/1ps

module dcache_way_merge (
    input  logic                                           clk,
    input  logic                                           rst,
    input  dcache_pkg::way_rd_t [dcache_pkg::NUM_WAYS-1:0] ways_i,
    input  logic [dcache_pkg::TAG_W-1:0]                   lookup_tag_i,
    input  logic                                           touch_i,
    input  logic                                           touch_way_i,
    input  logic [dcache_pkg::INDEX_W-1:0]                 touch_index_i,
    output logic                                           hit_o,
    output logic                                           hit_way_o,
    output logic [dcache_pkg::LINE_W-1:0]                  hit_line_o,
    output logic                                           victim_way_o,
    output dcache_pkg::tag_entry_t                         victim_entry_o,
    output logic [dcache_pkg::LINE_W-1:0]                  victim_line_o
);
    import dcache_pkg::*;

    logic [NUM_WAYS-1:0] hit_vec;
    logic [NUM_SETS-1:0] ru_q;          // way used last, per set
    logic                hit_sel_q;
    logic                victim_sel_q;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = ways_i[w].entry.valid && (ways_i[w].entry.tag == lookup_tag_i);
        end
    end

    assign hit_o     = |hit_vec;
    assign hit_way_o = hit_vec[1];

    // invalid way first, then the one not used last
    always_comb begin
        if (!ways_i[0].entry.valid) begin
            victim_way_o = 1'b0;
        end else if (!ways_i[1].entry.valid) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = ~ru_q[touch_index_i];
        end
    end

    assign victim_entry_o = ways_i[victim_way_o].entry;

    always_ff @(posedge clk) begin
        if (rst) begin
            ru_q <= '0;
        end else if (touch_i) begin
            ru_q[touch_index_i] <= touch_way_i;
        end
    end

    // line data shows up a cycle after the lookup, so keep the way choices
    always_ff @(posedge clk) begin
        if (touch_i) begin
            hit_sel_q    <= hit_way_o;
            victim_sel_q <= victim_way_o;
        end
    end

    assign hit_line_o    = ways_i[hit_sel_q].line;
    assign victim_line_o = ways_i[victim_sel_q].line;

    // a tag lives in at most one way of a set
    assert property (@(posedge clk) disable iff (rst) touch_i |-> $onehot0(hit_vec));

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing --top-module tb_dcache -f files.f -o tb_dcache \
    && ./obj_dir/tb_dcache | grep -q "Simulation PASSED" \
    && echo "run passed" && exit 0 \
    || { echo "run failed"; exit 1; }

//--- tests/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rd_req_i,
    input  logic [dcache_pkg::ADDR_W-1:0] rd_addr_i,
    output logic                          rd_ready_o,
    output logic [dcache_pkg::DATA_W-1:0] rdata_o,
    output logic                          rvalid_o,
    output logic                          rlast_o,
    input  logic                          wr_req_i,
    input  dcache_pkg::mem_wr_t           wr_i,
    output logic                          wr_ready_o
);
    import dcache_pkg::*;

    logic [LINE_W-1:0] store [logic [ADDR_W-1:0]];  // lines written back so far
    logic [LINE_W-1:0] line_q;
    logic              sending;
    logic              beat;

    // untouched lines hold a pattern built from the whole line address
    function automatic logic [LINE_W-1:0] line_fill(input logic [ADDR_W-1:0] a);
        return {a ^ 32'hdead_beef, ~a, a * 32'd2654435761, {a[15:0], a[31:16]}};
    endfunction

    function automatic logic [LINE_W-1:0] line_read(input logic [ADDR_W-1:0] a);
        return store.exists(a) ? store[a] : line_fill(a);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ready_o <= 1'b0;
            wr_ready_o <= 1'b0;
            rvalid_o   <= 1'b0;
            rlast_o    <= 1'b0;
            rdata_o    <= '0;
            sending    <= 1'b0;
            beat       <= 1'b0;
        end else begin
            rd_ready_o <= 1'b0;
            wr_ready_o <= 1'b0;
            rvalid_o   <= 1'b0;
            rlast_o    <= 1'b0;
            if (sending) begin                   // lower half goes out first
                rvalid_o <= 1'b1;
                rdata_o  <= line_q[beat*DATA_W +: DATA_W];
                rlast_o  <= beat;
                beat     <= ~beat;
                sending  <= !beat;
            end else if (rd_req_i && rd_ready_o) begin
                line_q  <= line_read(rd_addr_i);
                sending <= 1'b1;
                beat    <= 1'b0;
            end else if (rd_req_i && ($urandom % 4 == 0)) begin
                rd_ready_o <= 1'b1;               // random stall before accepting
            end
            if (wr_req_i && wr_ready_o) begin
                store[wr_i.addr] = wr_i.line;
            end else if (wr_req_i && ($urandom % 3 == 0)) begin
                wr_ready_o <= 1'b1;
            end
        end
    end

endmodule

//--- tests/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int LIMIT = 2000;

    logic              clk;
    logic              rst;
    logic              req_valid_i;
    cpu_req_t          req_i;
    logic              req_ready_o;
    logic              resp_valid_o;
    logic [DATA_W-1:0] resp_data_o;
    logic              mem_rd_req_o;
    logic [ADDR_W-1:0] mem_rd_addr_o;
    logic              mem_rd_ready_i;
    logic [DATA_W-1:0] mem_rdata_i;
    logic              mem_rvalid_i;
    logic              mem_rlast_i;
    logic              mem_wr_req_o;
    mem_wr_t           mem_wr_o;
    logic              mem_wr_ready_i;

    logic [7:0]        ref_mem [logic [ADDR_W-1:0]];  // CPU view of memory per byte
    int                errors = 0;
    int                accepts = 0;
    int                resps = 0;
    int                wb_cnt = 0;
    int                rd_cnt = 0;
    logic              started = 1'b0;
    logic              outstanding;
    logic              cur_op = 1'b0;
    logic [ADDR_W-1:0] cur_addr = '0;
    logic              expect_hit = 1'b0;
    logic              wb_allowed = 1'b1;
    logic              wb_addr_known = 1'b0;
    logic [ADDR_W-1:0] wb_addr = '0;           // victim line address when predictable
    logic [DATA_W-1:0] exp_data = '0;
    logic              accept;

    dcache_top UUT (.*);

    mem_model u_mem (
        .clk, .rst, .rd_req_i(mem_rd_req_o), .rd_addr_i(mem_rd_addr_o),
        .rd_ready_o(mem_rd_ready_i), .rdata_o(mem_rdata_i), .rvalid_o(mem_rvalid_i),
        .rlast_o(mem_rlast_i), .wr_req_i(mem_wr_req_o), .wr_i(mem_wr_o),
        .wr_ready_o(mem_wr_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign accept = req_valid_i && req_ready_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else begin
            if (accept) accepts++;
            if (resp_valid_o) resps++;
            if (mem_wr_req_o && mem_wr_ready_i) wb_cnt++;
            if (mem_rd_req_o && mem_rd_ready_i) rd_cnt++;
            if (accept) outstanding <= 1'b1;
            else if (resp_valid_o) outstanding <= 1'b0;
        end
    end

    // untouched memory holds the model's fill pattern
    function automatic logic [LINE_W-1:0] initial_line(input logic [ADDR_W-1:0] a);
        return {a ^ 32'hdead_beef, ~a, a * 32'd2654435761, {a[15:0], a[31:16]}};
    endfunction

    function automatic logic [7:0] ref_byte(input logic [ADDR_W-1:0] a);
        logic [LINE_W-1:0] l;
        l = initial_line({a[ADDR_W-1:OFFSET_W], 4'h0});
        return ref_mem.exists(a) ? ref_mem[a] : l[a[3:0]*8 +: 8];
    endfunction

    function automatic logic [DATA_W-1:0] ref_half(input logic [ADDR_W-1:0] a);
        logic [DATA_W-1:0] d;
        for (int i = 0; i < 8; i++) d[i*8 +: 8] = ref_byte({a[ADDR_W-1:3], 3'(i)});
        return d;
    endfunction

    function automatic logic [LINE_W-1:0] ref_line(input logic [ADDR_W-1:0] a);
        return {ref_half({a[ADDR_W-1:4], 4'h8}), ref_half({a[ADDR_W-1:4], 4'h0})};
    endfunction

    // checks
    assert property (@(posedge clk) disable iff (rst)
        !started |-> req_ready_o && !resp_valid_o && !mem_rd_req_o && !mem_wr_req_o)
        else begin
            errors++;
            $display("idle outputs wrong after reset at %0t", $time);
        end
    assert property (@(posedge clk) disable iff (rst)
        resp_valid_o && !cur_op |-> resp_data_o == exp_data)
        else begin
            errors++;
            $display("[ERROR] %0t resp_data_o got %h expected %h", $time, resp_data_o, exp_data);
        end
    assert property (@(posedge clk) disable iff (rst)
        mem_rd_req_o |-> mem_rd_addr_o == {cur_addr[ADDR_W-1:4], 4'h0})
        else begin
            errors++;
            $display("[ERROR] %0t mem_rd_addr_o got %h expected %h", $time, mem_rd_addr_o,
                     {cur_addr[ADDR_W-1:4], 4'h0});
        end
    assert property (@(posedge clk) disable iff (rst) accept && expect_hit |=> resp_valid_o)
        else begin
            errors++;
            $display("hit response late at %0t", $time);
        end
    assert property (@(posedge clk) disable iff (rst) outstanding && expect_hit |-> !mem_rd_req_o)
        else begin
            errors++;
            $display("memory read on an expected hit at %0t", $time);
        end
    assert property (@(posedge clk) disable iff (rst) resp_valid_o |-> outstanding)
        else begin
            errors++;
            $display("response without a request at %0t", $time);
        end
    assert property (@(posedge clk) disable iff (rst) mem_wr_req_o |-> wb_allowed)
        else begin
            errors++;
            $display("write-back of a clean victim at %0t", $time);
        end
    assert property (@(posedge clk) disable iff (rst)
        mem_wr_req_o && wb_addr_known |-> mem_wr_o.addr == wb_addr)
        else begin
            errors++;
            $display("[ERROR] %0t mem_wr_o.addr got %h expected %h", $time, mem_wr_o.addr,
                     wb_addr);
        end
    assert property (@(posedge clk) disable iff (rst)
        mem_wr_req_o |-> mem_wr_o.line == ref_line(mem_wr_o.addr))
        else begin
            errors++;
            $display("[ERROR] %0t mem_wr_o.line got %h expected %h", $time, mem_wr_o.line,
                     ref_line(mem_wr_o.addr));
        end
    assert property (@(posedge clk) disable iff (rst)
        mem_rd_req_o && !mem_rd_ready_i |=> mem_rd_req_o && $stable(mem_rd_addr_o))
        else begin
            errors++;
            $display("read request dropped under stall at %0t", $time);
        end
    assert property (@(posedge clk) disable iff (rst)
        mem_wr_req_o && !mem_wr_ready_i |=> mem_wr_req_o && $stable(mem_wr_o))
        else begin
            errors++;
            $display("write request dropped under stall at %0t", $time);
        end

    task automatic give_up(input string what);
        $display("timeout waiting for %s at %0t", what, $time);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic send_request(input logic op, input logic [ADDR_W-1:0] addr,
                                input logic [7:0] strb, input logic [DATA_W-1:0] data,
                                input logic hit_expected);
        int waited;
        cur_op     = op;
        cur_addr   = addr;
        expect_hit = hit_expected;
        if (!op) exp_data = ref_half(addr);
        else for (int i = 0; i < 8; i++)
            if (strb[i]) ref_mem[{addr[ADDR_W-1:3], 3'(i)}] = data[i*8 +: 8];
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_i       <= '{op: op, addr: addr, wstrb: strb, wdata: data};
        started     = 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > LIMIT) give_up("req_ready_o");
        end while (!req_ready_o);
        req_valid_i <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > LIMIT) give_up("resp_valid_o");
        end while (!resp_valid_o);
    endtask

    function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set, input bit hi);
        return {22'h01234 + 22'(tag * 'h111), 6'(set), hi, 3'b0};
    endfunction

    initial begin
        int wb_before;
        void'($urandom(32'h0c9f_cd13));
        rst = 1'b1;
        req_valid_i = 1'b0;
        req_i = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        // three tags in one fresh set
        send_request(0, make_addr(0, 40, 0), 8'h00, '0, 0);       // cold miss
        assert (rd_cnt == 1)
            else begin
                errors++;
                $display("cold read miss did not read memory");
            end
        send_request(0, make_addr(0, 40, 1), 8'h00, '0, 1);       // hit
        send_request(1, make_addr(0, 40, 1), 8'h5a, 64'h0123_4567_89ab_cdef, 1);
        send_request(0, make_addr(0, 40, 1), 8'h00, '0, 1);
        send_request(0, make_addr(1, 40, 0), 8'h00, '0, 0);
        send_request(0, make_addr(0, 40, 0), 8'h00, '0, 1);       // marks tag 0 recent
        wb_allowed = 1'b0;
        send_request(0, make_addr(2, 40, 0), 8'h00, '0, 0);       // clean victim
        wb_allowed = 1'b1;
        send_request(0, make_addr(0, 40, 1), 8'h00, '0, 1);
        send_request(0, make_addr(2, 40, 1), 8'h00, '0, 1);
        wb_before = wb_cnt;
        wb_addr = make_addr(0, 40, 0);
        wb_addr_known = 1'b1;
        send_request(0, make_addr(1, 40, 1), 8'h00, '0, 0);       // dirty victim
        wb_addr_known = 1'b0;
        assert (wb_cnt == wb_before + 1)
            else begin
                errors++;
                $display("dirty line was not written back");
            end
        send_request(1, make_addr(0, 40, 0), 8'hc3, 64'hfeed_face_cafe_f00d, 0);  // write miss
        send_request(0, make_addr(0, 40, 0), 8'h00, '0, 1);
        for (int n = 0; n < 300; n++) begin
            send_request(1'($urandom % 2),
                         make_addr($urandom % 3, $urandom % 4, 1'($urandom % 2)),
                         8'($urandom), {$urandom, $urandom}, 0);
        end
        repeat (4) @(posedge clk);
        $display("errors %0d, accepted %0d, responses %0d", errors, accepts, resps);
        if (errors == 0 && accepts == resps) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
